/* files.f */
+incdir+include
logic/nocPkg.sv
logic/packetTimer.sv
logic/outputArbiter.sv
logic/switchMux.sv
logic/routerOutputPort.sv
verification/arbiterModel.sv
verification/routerOutputPortTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the router output port testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f files.f \
  --top-module routerOutputPortTb \
  -o simRouter

# the simulator's exit status is not used, the log decides
./obj_dir/simRouter 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

/* verification/routerOutputPortTb.sv */
`default_nettype none
`include "nocDefs.svh"

module routerOutputPortTb;

  import nocPkg::*;

  localparam int DIRECTED_CYCLES = 100;
  localparam int RANDOM_CYCLES   = 2000;
  localparam int TOTAL_CYCLES    = DIRECTED_CYCLES + RANDOM_CYCLES;

  logic        clk;
  logic        rst;
  flitWord_t   flit [5];
  logic [4:0]  req;
  logic [4:0]  grant;
  flitWord_t   outFlit;
  logic        outValid;
  int          phase;
  int          errCount;
  int          cycles;
  logic [15:0] lfsr;

  routerOutputPort dut (
    .clk(clk), .rst(rst),
    .flitL(flit[PORT_L]), .flitN(flit[PORT_N]), .flitE(flit[PORT_E]),
    .flitW(flit[PORT_W]), .flitS(flit[PORT_S]),
    .reqL(req[PORT_L]), .reqN(req[PORT_N]), .reqE(req[PORT_E]),
    .reqW(req[PORT_W]), .reqS(req[PORT_S]),
    .grant(grant), .outFlit(outFlit), .outValid(outValid)
  );

  arbiterModel model (
    .clk(clk), .rst(rst),
    .flitL(flit[PORT_L]), .flitN(flit[PORT_N]), .flitE(flit[PORT_E]),
    .flitW(flit[PORT_W]), .flitS(flit[PORT_S]),
    .reqL(req[PORT_L]), .reqN(req[PORT_N]), .reqE(req[PORT_E]),
    .reqW(req[PORT_W]), .reqS(req[PORT_S]),
    .grant(grant), .outFlit(outFlit), .outValid(outValid),
    .phase(phase), .errCount(errCount)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [15:0] randBits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsrStep(lfsr);
      v = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic flitWord_t makeFlit(input logic isHead, input logic [`LEN_W-1:0] len,
                                         input logic [15:0] bits);
    flitWord_t f;
    if (isHead)
    begin
      f.head.flitId = `FLIT_HEAD;
      f.head.length = len;
      f.head.dest   = {1'b0, bits};
    end
    else
    begin
      f.body.flitId  = `FLIT_BODY;
      f.body.payload = {13'd0, bits};
    end
    return f;
  endfunction

  // drive point is 1 unit past the rising edge
  task automatic nextCycle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
  endtask

  task automatic startPacket(input int p, input logic [`LEN_W-1:0] len);
    flit[p] = makeFlit(1'b1, len, 16'(cycles));
    req[p]  = 1'b1;
  endtask

  task automatic continuePacket(input int p);
    flit[p] = makeFlit(1'b0, '0, 16'(cycles * 8 + p));
  endtask

  task automatic stopPacket(input int p);
    flit[p] = '0;
    req[p]  = 1'b0;
  endtask

  initial
  begin
    logic [15:0] len;
    rst    = 1'b1;
    req    = '0;
    phase  = 0;
    cycles = 0;
    lfsr   = 16'd14074;
    for (int p = 0; p < 5; p++)
      flit[p] = '0;
    nextCycle(3);
    rst = 1'b0;
    nextCycle(2);

    phase = 1;  // N, E and S start together, N wins
    startPacket(PORT_N, 12'd1);
    startPacket(PORT_E, 12'd0);
    startPacket(PORT_S, 12'd2);
    nextCycle(1);
    continuePacket(PORT_N);
    continuePacket(PORT_E);
    continuePacket(PORT_S);
    nextCycle(12);
    for (int p = 0; p < 5; p++)
      stopPacket(p);
    nextCycle(3);

    phase = 2;  // lone requester, length 0 then 5
    startPacket(PORT_W, 12'd0);
    nextCycle(1);
    continuePacket(PORT_W);
    nextCycle(4);
    stopPacket(PORT_W);
    nextCycle(2);
    startPacket(PORT_W, 12'd5);
    nextCycle(1);
    continuePacket(PORT_W);
    nextCycle(14);
    stopPacket(PORT_W);
    nextCycle(2);

    phase = 3;  // S then wrap to L, then on to E
    startPacket(PORT_S, 12'd1);
    nextCycle(1);
    continuePacket(PORT_S);
    startPacket(PORT_L, 12'd1);
    startPacket(PORT_E, 12'd2);
    nextCycle(15);
    for (int p = 0; p < 5; p++)
      stopPacket(p);
    nextCycle(2);

    phase = 4;
    startPacket(PORT_E, 12'd7);
    nextCycle(1);
    continuePacket(PORT_E);
    nextCycle(3);
    startPacket(PORT_N, 12'd2);
    nextCycle(1);
    stopPacket(PORT_E);  // hand over to N before E's timer ends
    continuePacket(PORT_N);
    nextCycle(6);
    stopPacket(PORT_N);
    nextCycle(2);
    startPacket(PORT_L, 12'd7);
    nextCycle(3);
    stopPacket(PORT_L);  // nobody else waiting, back to idle
    nextCycle(3);

    phase = 5;
    for (int c = 0; c < RANDOM_CYCLES; c++)
    begin
      for (int p = 0; p < 5; p++)
      begin
        req[p] = (randBits(2) != 16'd0);
        if (randBits(1) != 16'd0)
        begin
          len     = randBits(3);
          flit[p] = makeFlit(1'b1, len[`LEN_W-1:0], randBits(16));
        end
        else
          flit[p] = makeFlit(1'b0, '0, randBits(16));
      end
      nextCycle(1);
    end
    for (int p = 0; p < 5; p++)
      stopPacket(p);
    nextCycle(3);

    $display("cycles %0d errors %0d", cycles, errCount);
    if (errCount == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #((TOTAL_CYCLES + 20) * 8);
    $display("timeout: the run did not finish within %0d clock cycles", TOTAL_CYCLES + 20);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/arbiterModel.sv */
`default_nettype none
`include "nocDefs.svh"

module arbiterModel (
  input  logic              clk,
  input  logic              rst,
  input  nocPkg::flitWord_t flitL,
  input  nocPkg::flitWord_t flitN,
  input  nocPkg::flitWord_t flitE,
  input  nocPkg::flitWord_t flitW,
  input  nocPkg::flitWord_t flitS,
  input  logic              reqL,
  input  logic              reqN,
  input  logic              reqE,
  input  logic              reqW,
  input  logic              reqS,
  input  logic [4:0]        grant,
  input  nocPkg::flitWord_t outFlit,
  input  logic              outValid,
  input  int                phase,
  output int                errCount
);

  import nocPkg::*;

  flitWord_t         flitIn [5];
  logic [4:0]        reqIn;
  logic [`LEN_W-1:0] limit [5];
  logic [`LEN_W-1:0] count [5];
  logic [4:0]        hold;
  logic [4:0]        expGrant;
  logic              expValid;
  flitWord_t         expFlit;
  logic              flitSeen;  // outFlit is defined once a flit went out
  int                owner;     // -1 while idle
  int                nextOwn;
  int                errors = 0;

  // grant kept, else first requester after cur with cur itself last
  function automatic int nextOwner(input int cur, input logic [4:0] r, input logic keep);
    int p;
    if (keep)
      return cur;
    for (int k = 1; k <= 5; k++)
    begin
      p = (cur < 0) ? k - 1 : (cur + k) % 5;
      if (r[p])
        return p;
    end
    return -1;
  endfunction

  function automatic string testName(input int ph);
    case (ph)
      0: return "reset";
      1: return "entryPriority";
      2: return "timedHold";
      3: return "rotation";
      4: return "earlyRelease";
      default: return "randomTraffic";
    endcase
  endfunction

  always_comb
  begin
    flitIn[PORT_L] = flitL;
    flitIn[PORT_N] = flitN;
    flitIn[PORT_E] = flitE;
    flitIn[PORT_W] = flitW;
    flitIn[PORT_S] = flitS;
    reqIn = {reqS, reqW, reqE, reqN, reqL};
    hold = '0;
    if (owner >= 0 && reqIn[owner] && count[owner] != limit[owner])
      hold[owner] = 1'b1;
    nextOwn = nextOwner(owner, reqIn, |hold);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      owner    <= -1;
      expValid <= 1'b0;
      flitSeen <= 1'b0;
      for (int i = 0; i < 5; i++)
      begin
        limit[i] <= '0;
        count[i] <= '0;
      end
    end
    else
    begin
      owner <= nextOwn;
      for (int i = 0; i < 5; i++)
      begin
        if (flitIn[i].head.flitId == `FLIT_HEAD)
          limit[i] <= flitIn[i].head.length;
        count[i] <= hold[i] ? count[i] + 1'b1 : '0;
      end
      expValid <= (owner >= 0) && reqIn[owner];
      if (owner >= 0 && reqIn[owner])
      begin
        expFlit  <= flitIn[owner];
        flitSeen <= 1'b1;
      end
    end
  end

  assign expGrant = (owner >= 0) ? 5'(1 << owner) : 5'd0;
  assign errCount = errors;

  // ********************
  // checks against the DUT

  resetClear: assert property (@(posedge clk) $fell(rst) |-> (grant == 5'd0) && !outValid)
    else
    begin
      $display("error %s resetClear: expected grant 00000 valid 0, actual grant %b valid %b",
               testName(phase), $sampled(grant), $sampled(outValid));
      errors++;
    end

  grantCheck: assert property (@(posedge clk) disable iff (rst) grant == expGrant)
    else
    begin
      $display("error %s grantCheck: expected %b, actual %b",
               testName(phase), $sampled(expGrant), $sampled(grant));
      errors++;
    end

  validCheck: assert property (@(posedge clk) disable iff (rst) outValid == expValid)
    else
    begin
      $display("error %s validCheck: expected %b, actual %b",
               testName(phase), $sampled(expValid), $sampled(outValid));
      errors++;
    end

  flitCheck: assert property (@(posedge clk) disable iff (rst) flitSeen |-> outFlit == expFlit)
    else
    begin
      $display("error %s flitCheck: expected %h, actual %h",
               testName(phase), $sampled(expFlit), $sampled(outFlit));
      errors++;
    end

endmodule

`default_nettype wire

/* logic/routerOutputPort.sv */
`default_nettype none
`include "nocDefs.svh"

module routerOutputPort (
  input  logic              clk,
  input  logic              rst,
  input  nocPkg::flitWord_t flitL,
  input  nocPkg::flitWord_t flitN,
  input  nocPkg::flitWord_t flitE,
  input  nocPkg::flitWord_t flitW,
  input  nocPkg::flitWord_t flitS,
  input  logic              reqL,
  input  logic              reqN,
  input  logic              reqE,
  input  logic              reqW,
  input  logic              reqS,
  output logic [4:0]        grant,
  output nocPkg::flitWord_t outFlit,
  output logic              outValid
);

  // head view fields for the packet timers, body flits are ignored by id
  logic [`ID_W-1:0]  flitIdL, flitIdN, flitIdE, flitIdW, flitIdS;
  logic [`LEN_W-1:0] lengthL, lengthN, lengthE, lengthW, lengthS;

  assign flitIdL = flitL.head.flitId;
  assign flitIdN = flitN.head.flitId;
  assign flitIdE = flitE.head.flitId;
  assign flitIdW = flitW.head.flitId;
  assign flitIdS = flitS.head.flitId;

  assign lengthL = flitL.head.length;
  assign lengthN = flitN.head.length;
  assign lengthE = flitE.head.length;
  assign lengthW = flitW.head.length;
  assign lengthS = flitS.head.length;

  outputArbiter arb (
    .clk     (clk),
    .rst     (rst),
    .flitIdL (flitIdL),
    .flitIdN (flitIdN),
    .flitIdE (flitIdE),
    .flitIdW (flitIdW),
    .flitIdS (flitIdS),
    .lengthL (lengthL),
    .lengthN (lengthN),
    .lengthE (lengthE),
    .lengthW (lengthW),
    .lengthS (lengthS),
    .reqL    (reqL),
    .reqN    (reqN),
    .reqE    (reqE),
    .reqW    (reqW),
    .reqS    (reqS),
    .grant   (grant)
  );

  switchMux mux (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .reqL     (reqL),
    .reqN     (reqN),
    .reqE     (reqE),
    .reqW     (reqW),
    .reqS     (reqS),
    .flitL    (flitL),
    .flitN    (flitN),
    .flitE    (flitE),
    .flitW    (flitW),
    .flitS    (flitS),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

`default_nettype wire

/* logic/switchMux.sv */
`default_nettype none

module switchMux (
  input  logic              clk,
  input  logic              rst,
  input  logic [4:0]        grant,
  input  logic              reqL,
  input  logic              reqN,
  input  logic              reqE,
  input  logic              reqW,
  input  logic              reqS,
  input  nocPkg::flitWord_t flitL,
  input  nocPkg::flitWord_t flitN,
  input  nocPkg::flitWord_t flitE,
  input  nocPkg::flitWord_t flitW,
  input  nocPkg::flitWord_t flitS,
  output nocPkg::flitWord_t outFlit,
  output logic              outValid
);

  import nocPkg::*;

  flitWord_t selFlit;
  logic      selReq;

  // grant is one-hot or zero
  always_comb
  begin
    selFlit = flitL;
    selReq  = 1'b0;
    case (1'b1)
      grant[PORT_L]:
      begin
        selFlit = flitL;
        selReq  = reqL;
      end
      grant[PORT_N]:
      begin
        selFlit = flitN;
        selReq  = reqN;
      end
      grant[PORT_E]:
      begin
        selFlit = flitE;
        selReq  = reqE;
      end
      grant[PORT_W]:
      begin
        selFlit = flitW;
        selReq  = reqW;
      end
      grant[PORT_S]:
      begin
        selFlit = flitS;
        selReq  = reqS;
      end
      default: selReq = 1'b0;  // idle so nothing is forwarded
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= selReq;
  end

  always_ff @(posedge clk)
  begin
    if (selReq)
      outFlit <= selFlit;  // holds the last flit otherwise
  end

  // a forwarded flit came from exactly one granted input
  validNeedsGrant: assert property (
    @(posedge clk) disable iff (rst)
    outValid |-> $past($onehot(grant))
  );

endmodule

`default_nettype wire

/* logic/outputArbiter.sv */
`default_nettype none
`include "nocDefs.svh"

module outputArbiter (
  input  logic              clk,
  input  logic              rst,
  input  logic [`ID_W-1:0]  flitIdL,
  input  logic [`ID_W-1:0]  flitIdN,
  input  logic [`ID_W-1:0]  flitIdE,
  input  logic [`ID_W-1:0]  flitIdW,
  input  logic [`ID_W-1:0]  flitIdS,
  input  logic [`LEN_W-1:0] lengthL,
  input  logic [`LEN_W-1:0] lengthN,
  input  logic [`LEN_W-1:0] lengthE,
  input  logic [`LEN_W-1:0] lengthW,
  input  logic [`LEN_W-1:0] lengthS,
  input  logic              reqL,
  input  logic              reqN,
  input  logic              reqE,
  input  logic              reqW,
  input  logic              reqS,
  output logic [4:0]        grant
);

  import nocPkg::*;

  arbState_t  state;
  arbState_t  nextState;
  logic [4:0] req;
  logic [4:0] runTimer;
  logic [4:0] timesUp;

  // first requester in the rotation after last, with last itself checked at the end
  function automatic arbState_t pickNext(input logic [4:0] reqVec, input int last);
    arbState_t pick;
    int        idx;
    pick = ST_IDLE;
    // walk from the farthest to the nearest so the nearest wins
    for (int i = 5; i >= 1; i--)
    begin
      idx = (last + i) % 5;
      if (reqVec[idx])
        pick = arbState_t'(6'b000010 << idx);
    end
    return pick;
  endfunction

  always_comb
  begin
    req[PORT_L] = reqL;
    req[PORT_N] = reqN;
    req[PORT_E] = reqE;
    req[PORT_W] = reqW;
    req[PORT_S] = reqS;
  end

  // ********************
  // packet timers

  packetTimer timerL (
    .clk      (clk),
    .rst      (rst),
    .flitId   (flitIdL),
    .length   (lengthL),
    .runTimer (runTimer[PORT_L]),
    .timesUp  (timesUp[PORT_L])
  );

  packetTimer timerN (
    .clk      (clk),
    .rst      (rst),
    .flitId   (flitIdN),
    .length   (lengthN),
    .runTimer (runTimer[PORT_N]),
    .timesUp  (timesUp[PORT_N])
  );

  packetTimer timerE (
    .clk      (clk),
    .rst      (rst),
    .flitId   (flitIdE),
    .length   (lengthE),
    .runTimer (runTimer[PORT_E]),
    .timesUp  (timesUp[PORT_E])
  );

  packetTimer timerW (
    .clk      (clk),
    .rst      (rst),
    .flitId   (flitIdW),
    .length   (lengthW),
    .runTimer (runTimer[PORT_W]),
    .timesUp  (timesUp[PORT_W])
  );

  packetTimer timerS (
    .clk      (clk),
    .rst      (rst),
    .flitId   (flitIdS),
    .length   (lengthS),
    .runTimer (runTimer[PORT_S]),
    .timesUp  (timesUp[PORT_S])
  );

  // ********************
  // state register and next state

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ST_IDLE;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = ST_IDLE;
    runTimer  = '0;
    case (state)
      ST_IDLE: nextState = pickNext(req, PORT_S);  // plain L, N, E, W, S order
      ST_L:
      begin
        if (req[PORT_L] && !timesUp[PORT_L])
        begin
          nextState        = ST_L;
          runTimer[PORT_L] = 1'b1;
        end
        else
          nextState = pickNext(req, PORT_L);
      end
      ST_N:
      begin
        if (req[PORT_N] && !timesUp[PORT_N])
        begin
          nextState        = ST_N;
          runTimer[PORT_N] = 1'b1;
        end
        else
          nextState = pickNext(req, PORT_N);
      end
      ST_E:
      begin
        if (req[PORT_E] && !timesUp[PORT_E])
        begin
          nextState        = ST_E;
          runTimer[PORT_E] = 1'b1;
        end
        else
          nextState = pickNext(req, PORT_E);
      end
      ST_W:
      begin
        if (req[PORT_W] && !timesUp[PORT_W])
        begin
          nextState        = ST_W;
          runTimer[PORT_W] = 1'b1;
        end
        else
          nextState = pickNext(req, PORT_W);
      end
      ST_S:
      begin
        if (req[PORT_S] && !timesUp[PORT_S])
        begin
          nextState        = ST_S;
          runTimer[PORT_S] = 1'b1;
        end
        else
          nextState = pickNext(req, PORT_S);
      end
      default: nextState = ST_IDLE;  // back to idle from a broken encoding
    endcase
  end

  assign grant = state[5:1];

  // ********************
  // checks

  stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state));

  // a new grant comes from a request
  for (genvar p = 0; p < 5; p++)
  begin : gEntryCheck
    grantEntry: assert property (
      @(posedge clk) disable iff (rst)
      $rose(grant[p]) |-> $past(req[p])
    );
  end

endmodule

`default_nettype wire

/* logic/packetTimer.sv */
`default_nettype none
`include "nocDefs.svh"

module packetTimer (
  input  logic              clk,
  input  logic              rst,
  input  logic [`ID_W-1:0]  flitId,
  input  logic [`LEN_W-1:0] length,
  input  logic              runTimer,
  output logic              timesUp
);

  logic [`LEN_W-1:0] limit;
  logic [`LEN_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == `FLIT_HEAD)
        limit <= length;  // any head flit on this input, granted or not
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;  // restart for the next grant
    end
  end

  assign timesUp = (count == limit);

  // the arbiter must release runTimer once the limit is hit
  countStopsAtLimit: assert property (
    @(posedge clk) disable iff (rst)
    (count == limit) |-> ##1 (count != limit + 1'b1) || (limit == '1)
  );

endmodule

`default_nettype wire

/* logic/nocPkg.sv */
`default_nettype none
`include "nocDefs.svh"

package nocPkg;

  typedef struct packed {
    logic [`ID_W-1:0]                flitId;
    logic [`LEN_W-1:0]               length;  // packet length in flits
    logic [`FLIT_W-`ID_W-`LEN_W-1:0] dest;
  } headView_t;

  typedef struct packed {
    logic [`ID_W-1:0]        flitId;
    logic [`FLIT_W-`ID_W-1:0] payload;
  } bodyView_t;

  // the same word read as a head flit or as a body flit
  typedef union packed {
    headView_t head;
    bodyView_t body;
  } flitWord_t;

  // one-hot arbiter state, bit 0 is idle
  typedef logic [5:0] arbState_t;

  localparam arbState_t ST_IDLE = 6'b000001;
  localparam arbState_t ST_L    = 6'b000010;
  localparam arbState_t ST_N    = 6'b000100;
  localparam arbState_t ST_E    = 6'b001000;
  localparam arbState_t ST_W    = 6'b010000;
  localparam arbState_t ST_S    = 6'b100000;

  // bit positions in the grant vector
  localparam int PORT_L = 0;
  localparam int PORT_N = 1;
  localparam int PORT_E = 2;
  localparam int PORT_W = 3;
  localparam int PORT_S = 4;

endpackage

`default_nettype wire

/* include/nocDefs.svh */
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

// flit field widths
`define FLIT_W 32
`define ID_W 3
`define LEN_W 12

// flit id codes
`define FLIT_NONE 3'd0
`define FLIT_HEAD 3'd1
`define FLIT_BODY 3'd2
`define FLIT_TAIL 3'd3

`endif
